// File: verilog/arcade_shell_pkg.sv
/*
 * Shared definitions for the arcade host shell.
 * Bridge register addresses, reset hold length and controller key bit positions.
 * Width typedefs, control panel, settings and core input structs.
 */

`default_nettype none

package arcade_shell_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // plain width types

    typedef logic [31:0] bridge_word_t;
    typedef logic [31:0] cont_key_t;
    typedef logic [7:0]  dip_byte_t;
    typedef logic [3:0]  scanline_t;
    typedef logic [13:0] hold_count_t;

    ////////////////////////////////////////////////////////////////////////////
    // bridge register map

    localparam bridge_word_t ADDR_RESET     = 32'hF000_0000;
    localparam bridge_word_t ADDR_DIP       = 32'hF100_0000;
    localparam bridge_word_t ADDR_MODE      = 32'hF200_0000;
    localparam bridge_word_t ADDR_SCANLINES = 32'hF300_0000;

    // value the host sees when reading the reset register
    localparam bridge_word_t RESET_READBACK = 32'd1;

    // core held in reset this many cycles after the last request
    localparam hold_count_t HOLD_CYCLES = 14'd8000;

    ////////////////////////////////////////////////////////////////////////////
    // controller key bitmap positions

    localparam int KEY_UP     = 0;
    localparam int KEY_DOWN   = 1;
    localparam int KEY_LEFT   = 2;
    localparam int KEY_RIGHT  = 3;
    localparam int KEY_FACE_B = 5;
    localparam int KEY_FACE_Y = 7;
    localparam int KEY_SELECT = 14;
    localparam int KEY_START  = 15;

    // arcade control panel, all fields active low at the core
    typedef struct packed {
        logic coin;
        logic start2;
        logic start1;
        logic fire2;
        logic fire1;
        logic up;
        logic down;
        logic left;
        logic right;
    } control_panel_t;

    typedef struct packed {
        dip_byte_t dsw0;
        dip_byte_t dsw1;
        dip_byte_t dsw2;
        dip_byte_t mode;
        scanline_t scanlines;
    } settings_t;

    typedef struct packed {
        control_panel_t controls;
        dip_byte_t      dip1;
        dip_byte_t      dip2;
        dip_byte_t      mode;
        scanline_t      scanlines;
    } core_inputs_t;

endpackage

`default_nettype wire

// File: verilog/bridge_settings_regs.sv
/*
 * Settings registers on the bridge bus.
 * Write decode, stored DIP / mode / scanline words, read buffer and read mux,
 * and the core reset request pulse.
 */

`timescale 1ns/100ps
`default_nettype none

module bridge_settings_regs (
    input  wire                            clk_74a,
    input  wire                            temp_reset,
    input  wire arcade_shell_pkg::bridge_word_t bridge_addr,
    input  wire arcade_shell_pkg::bridge_word_t bridge_wr_data,
    input  wire                            bridge_rd,
    input  wire                            bridge_wr,
    output arcade_shell_pkg::bridge_word_t bridge_rd_data,
    output arcade_shell_pkg::settings_t    settings,
    output logic                           reset_request
);
    import arcade_shell_pkg::*;

    // full words as written by the host
    bridge_word_t dsw_word;
    bridge_word_t mode_word;
    bridge_word_t scnl_word;
    bridge_word_t rd_buffer;
    logic         addr_mapped;

    ////////////////////////////////////////////////////////////////////////////
    // write side

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            dsw_word      <= '0;
            mode_word     <= '0;
            scnl_word     <= '0;
            reset_request <= 1'b0;
        end else begin
            // pulse lasts a single cycle
            reset_request <= 1'b0;
            if (bridge_wr) begin
                case (bridge_addr)
                    ADDR_RESET: reset_request <= 1'b1;
                    ADDR_DIP: begin
                        dsw_word      <= bridge_wr_data;
                        reset_request <= 1'b1;
                    end
                    ADDR_MODE:      mode_word <= bridge_wr_data;
                    ADDR_SCANLINES: scnl_word <= bridge_wr_data;
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read side

    // buffer loads on the strobe, host samples it a cycle later
    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            rd_buffer <= '0;
        end else if (bridge_rd) begin
            case (bridge_addr)
                ADDR_RESET:     rd_buffer <= RESET_READBACK;
                ADDR_DIP:       rd_buffer <= dsw_word;
                ADDR_MODE:      rd_buffer <= mode_word;
                ADDR_SCANLINES: rd_buffer <= scnl_word;
                default: ;
            endcase
        end
    end

    always_comb begin
        addr_mapped = (bridge_addr == ADDR_RESET) || (bridge_addr == ADDR_DIP) ||
                      (bridge_addr == ADDR_MODE) || (bridge_addr == ADDR_SCANLINES);
        bridge_rd_data = addr_mapped ? rd_buffer : '0;
    end

    // bytes of interest for the core
    always_comb begin
        settings.dsw0      = dsw_word[7:0];
        settings.dsw1      = dsw_word[15:8];
        settings.dsw2      = dsw_word[23:16];
        settings.mode      = mode_word[7:0];
        settings.scanlines = scnl_word[3:0];
    end

    // host side protocol, one strobe at a time
    strobe_exclusive_a: assert property (
        @(posedge clk_74a) disable iff (temp_reset) !(bridge_rd && bridge_wr)
    );

endmodule

`default_nettype wire

// File: verilog/player_input_merge.sv
/*
 * Two-player control merge.
 * Decodes both controller key bitmaps and registers the active-low panel.
 */

`timescale 1ns/100ps
`default_nettype none

module player_input_merge (
    input  wire                              clk_74a,
    input  wire                              temp_reset,
    input  wire arcade_shell_pkg::cont_key_t cont1_key,
    input  wire arcade_shell_pkg::cont_key_t cont2_key,
    output arcade_shell_pkg::control_panel_t panel
);
    import arcade_shell_pkg::*;

    control_panel_t p1_pressed;
    control_panel_t p2_pressed;
    control_panel_t merged;

    // active-high view of one pad, start lands in both start slots
    function automatic control_panel_t decode_keys(input cont_key_t key);
        control_panel_t p;
        p.coin   = key[KEY_SELECT];
        p.start2 = key[KEY_START];
        p.start1 = key[KEY_START];
        p.fire2  = key[KEY_FACE_Y];
        p.fire1  = key[KEY_FACE_B];
        p.up     = key[KEY_UP];
        p.down   = key[KEY_DOWN];
        p.left   = key[KEY_LEFT];
        p.right  = key[KEY_RIGHT];
        return p;
    endfunction

    always_comb begin
        p1_pressed = decode_keys(cont1_key);
        p2_pressed = decode_keys(cont2_key);
        // shared controls from either player
        merged = p1_pressed | p2_pressed;
        // each start button belongs to its own player
        merged.start1 = p1_pressed.start1;
        merged.start2 = p2_pressed.start2;
    end

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            panel <= '1;
        end else begin
            panel <= ~merged;
        end
    end

endmodule

`default_nettype wire

// File: verilog/core_control_stage.sv
/*
 * Core control stage.
 * Reset hold counter with the core run flag, and the registered core input word.
 */

`timescale 1ns/100ps
`default_nettype none

module core_control_stage (
    input  wire                                   clk_74a,
    input  wire                                   temp_reset,
    input  wire arcade_shell_pkg::settings_t      settings,
    input  wire                                   reset_request,
    input  wire arcade_shell_pkg::control_panel_t panel,
    output arcade_shell_pkg::core_inputs_t        core_inputs,
    output logic                                  core_run
);
    import arcade_shell_pkg::*;

    hold_count_t hold_count;

    ////////////////////////////////////////////////////////////////////////////
    // reset hold

    // any request reloads the full count
    always_ff @(posedge clk_74a) begin
        if (temp_reset || reset_request) begin
            hold_count <= HOLD_CYCLES;
            core_run   <= 1'b0;
        end else if (hold_count == '0) begin
            core_run <= 1'b1;
        end else begin
            hold_count <= hold_count - 1'b1;
            core_run   <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // core input word

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            // nothing pressed
            core_inputs.controls  <= '1;
            core_inputs.dip1      <= '0;
            core_inputs.dip2      <= '0;
            core_inputs.mode      <= '0;
            core_inputs.scanlines <= '0;
        end else begin
            core_inputs.controls  <= panel;
            core_inputs.dip1      <= settings.dsw0;
            core_inputs.dip2      <= settings.dsw1;
            core_inputs.mode      <= settings.mode;
            core_inputs.scanlines <= settings.scanlines;
        end
    end

    hold_count_range_a: assert property (
        @(posedge clk_74a) disable iff (temp_reset) hold_count <= HOLD_CYCLES
    );

    // a request from the bridge side stops the core on the very next cycle
    run_low_after_request_a: assert property (
        @(posedge clk_74a) (temp_reset || reset_request) |=> !core_run
    );

endmodule

`default_nettype wire

// File: verilog/arcade_host_shell.sv
/*
 * Host-facing shell of the arcade core.
 * Bridge settings registers and player merge side by side, feeding the core control stage.
 */

`timescale 1ns/100ps
`default_nettype none

module arcade_host_shell (
    input  wire                                 clk_74a,
    input  wire                                 temp_reset,
    input  wire arcade_shell_pkg::bridge_word_t bridge_addr,
    input  wire arcade_shell_pkg::bridge_word_t bridge_wr_data,
    input  wire                                 bridge_rd,
    input  wire                                 bridge_wr,
    output wire arcade_shell_pkg::bridge_word_t bridge_rd_data,
    input  wire arcade_shell_pkg::cont_key_t    cont1_key,
    input  wire arcade_shell_pkg::cont_key_t    cont2_key,
    output wire arcade_shell_pkg::core_inputs_t core_inputs,
    output wire                                 core_run
);
    import arcade_shell_pkg::*;

    settings_t      settings;
    control_panel_t panel;
    logic           reset_request;

    ////////////////////////////////////////////////////////////////////////////
    // host side

    bridge_settings_regs bridge_settings_regs_i (
        .clk_74a        ( clk_74a        ),
        .temp_reset     ( temp_reset     ),
        .bridge_addr    ( bridge_addr    ),
        .bridge_wr_data ( bridge_wr_data ),
        .bridge_rd      ( bridge_rd      ),
        .bridge_wr      ( bridge_wr      ),
        .bridge_rd_data ( bridge_rd_data ),
        .settings       ( settings       ),
        .reset_request  ( reset_request  )
    );

    player_input_merge player_input_merge_i (
        .clk_74a    ( clk_74a    ),
        .temp_reset ( temp_reset ),
        .cont1_key  ( cont1_key  ),
        .cont2_key  ( cont2_key  ),
        .panel      ( panel      )
    );

    ////////////////////////////////////////////////////////////////////////////
    // core side

    core_control_stage core_control_stage_i (
        .clk_74a       ( clk_74a       ),
        .temp_reset    ( temp_reset    ),
        .settings      ( settings      ),
        .reset_request ( reset_request ),
        .panel         ( panel         ),
        .core_inputs   ( core_inputs   ),
        .core_run      ( core_run      )
    );

endmodule

`default_nettype wire

// File: sim/arcade_host_shell_tb.sv
/*
 * Testbench for the arcade host shell.
 * Clock and reset, a stimulus table of bridge writes, reads, random pads and
 * run waits, and typed compare tasks against a model of the host register map.
 */

`timescale 1ns/100ps
`default_nettype none

module arcade_host_shell_tb;
    import arcade_shell_pkg::*;

    typedef enum logic [1:0] {STEP_WRITE, STEP_READ, STEP_PAD, STEP_WAIT_RUN} step_kind_t;

    typedef struct packed {
        step_kind_t   kind;
        bridge_word_t addr;
        bridge_word_t data;
        bridge_word_t exp_value;
    } step_t;

    localparam int RUN_TIMEOUT = int'(HOLD_CYCLES) + 50;

    logic           clk_74a;
    logic           temp_reset;
    bridge_word_t   bridge_addr;
    bridge_word_t   bridge_wr_data;
    logic           bridge_rd;
    logic           bridge_wr;
    bridge_word_t   bridge_rd_data;
    cont_key_t      cont1_key;
    cont_key_t      cont2_key;
    core_inputs_t   core_inputs;
    logic           core_run;

    step_t          steps[$];
    int             step_errors;
    int             passed_steps;
    int             failed_steps;
    logic [31:0]    rng;

    // what the host has written so far, and the panel the pads should give
    bridge_word_t   dip_word;
    bridge_word_t   mode_word;
    bridge_word_t   scnl_word;
    control_panel_t panel_model;

    arcade_host_shell arcade_host_shell_i (
        .clk_74a        ( clk_74a        ),
        .temp_reset     ( temp_reset     ),
        .bridge_addr    ( bridge_addr    ),
        .bridge_wr_data ( bridge_wr_data ),
        .bridge_rd      ( bridge_rd      ),
        .bridge_wr      ( bridge_wr      ),
        .bridge_rd_data ( bridge_rd_data ),
        .cont1_key      ( cont1_key      ),
        .cont2_key      ( cont2_key      ),
        .core_inputs    ( core_inputs    ),
        .core_run       ( core_run       )
    );

    initial begin
        clk_74a = 1'b0;
        forever #5 clk_74a = ~clk_74a;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // pads report pressed as 1 while the panel wants pressed as 0
    function automatic control_panel_t expected_panel(input cont_key_t k1, input cont_key_t k2);
        control_panel_t p;
        p.up     = !(k1[KEY_UP] || k2[KEY_UP]);
        p.down   = !(k1[KEY_DOWN] || k2[KEY_DOWN]);
        p.left   = !(k1[KEY_LEFT] || k2[KEY_LEFT]);
        p.right  = !(k1[KEY_RIGHT] || k2[KEY_RIGHT]);
        p.fire1  = !(k1[KEY_FACE_B] || k2[KEY_FACE_B]);
        p.fire2  = !(k1[KEY_FACE_Y] || k2[KEY_FACE_Y]);
        p.coin   = !(k1[KEY_SELECT] || k2[KEY_SELECT]);
        p.start1 = !k1[KEY_START];
        p.start2 = !k2[KEY_START];
        return p;
    endfunction

    function automatic core_inputs_t expected_core();
        core_inputs_t c;
        c.controls  = panel_model;
        c.dip1      = dip_word[7:0];
        c.dip2      = dip_word[15:8];
        c.mode      = mode_word[7:0];
        c.scanlines = scnl_word[3:0];
        return c;
    endfunction

    function automatic string kind_name(input step_kind_t kind);
        case (kind)
            STEP_WRITE: return "write";
            STEP_READ:  return "read";
            STEP_PAD:   return "pad";
            default:    return "wait for run";
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks

    task automatic check_word(input string name, input bridge_word_t got, input bridge_word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            step_errors++;
        end
    endtask

    task automatic check_inputs(input core_inputs_t got, input core_inputs_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: core_inputs is %h, expected %h", $time, got, exp);
            step_errors++;
        end
    endtask

    task automatic check_run(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: core_run is %b, expected %b", $time, got, exp);
            step_errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // step drivers

    task automatic add_step(input step_kind_t kind, input bridge_word_t addr,
                            input bridge_word_t data, input bridge_word_t exp_value);
        step_t s;
        s = '{kind, addr, data, exp_value};
        steps.push_back(s);
    endtask

    // exp_value bit 0 is core_run in the cycle after the request
    task automatic do_write(input step_t s);
        @(posedge clk_74a);
        bridge_addr    <= s.addr;
        bridge_wr_data <= s.data;
        bridge_wr      <= 1'b1;
        @(posedge clk_74a);
        bridge_wr <= 1'b0;
        case (s.addr)
            ADDR_DIP:       dip_word = s.data;
            ADDR_MODE:      mode_word = s.data;
            ADDR_SCANLINES: scnl_word = s.data;
            default: ;
        endcase
        @(posedge clk_74a);
        @(negedge clk_74a);
        check_run(core_run, s.exp_value[0]);
        check_inputs(core_inputs, expected_core());
    endtask

    // address stays on the bus while the host samples the data
    task automatic do_read(input step_t s);
        @(posedge clk_74a);
        bridge_addr <= s.addr;
        bridge_rd   <= 1'b1;
        @(posedge clk_74a);
        bridge_rd <= 1'b0;
        @(negedge clk_74a);
        check_word("bridge_rd_data", bridge_rd_data, s.exp_value);
    endtask

    task automatic do_pad();
        cont_key_t k1;
        cont_key_t k2;
        rng = xorshift32(rng);
        k1  = rng;
        rng = xorshift32(rng);
        k2  = rng;
        @(posedge clk_74a);
        cont1_key <= k1;
        cont2_key <= k2;
        panel_model = expected_panel(k1, k2);
        @(posedge clk_74a);
        @(posedge clk_74a);
        @(negedge clk_74a);
        check_inputs(core_inputs, expected_core());
    endtask

    task automatic wait_for_run();
        int cycles;
        cycles = 0;
        while (core_run !== 1'b1 && cycles < RUN_TIMEOUT) begin
            @(negedge clk_74a);
            cycles++;
        end
        if (core_run !== 1'b1) begin
            $display("core_run did not rise within %0d cycles of the last request", RUN_TIMEOUT);
            step_errors++;
        end else begin
            check_inputs(core_inputs, expected_core());
        end
    endtask

    task automatic report_step(input int idx, input string what);
        if (step_errors == 0) begin
            passed_steps++;
            $display("step %0d %s: ok", idx, what);
        end else begin
            failed_steps++;
            $display("step %0d %s: %0d mismatch(es)", idx, what, step_errors);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        temp_reset     = 1'b1;
        bridge_addr    = '0;
        bridge_wr_data = '0;
        bridge_rd      = 1'b0;
        bridge_wr      = 1'b0;
        cont1_key      = '0;
        cont2_key      = '0;
        rng            = 32'h18a3_5646;
        passed_steps   = 0;
        failed_steps   = 0;
        dip_word       = '0;
        mode_word      = '0;
        scnl_word      = '0;
        panel_model    = '1;

        add_step(STEP_WAIT_RUN, '0, '0, '0);
        add_step(STEP_WRITE, ADDR_DIP, 32'h96A5_3C5A, 32'd0);
        add_step(STEP_WAIT_RUN, '0, '0, '0);
        add_step(STEP_WRITE, ADDR_MODE, 32'h1234_5603, 32'd1);
        add_step(STEP_WRITE, ADDR_SCANLINES, 32'hCAFE_0009, 32'd1);
        add_step(STEP_READ, ADDR_DIP, '0, 32'h96A5_3C5A);
        add_step(STEP_READ, ADDR_MODE, '0, 32'h1234_5603);
        add_step(STEP_READ, ADDR_SCANLINES, '0, 32'hCAFE_0009);
        add_step(STEP_READ, ADDR_RESET, '0, RESET_READBACK);
        add_step(STEP_READ, 32'hF400_0000, '0, 32'd0);
        repeat (24) add_step(STEP_PAD, '0, '0, '0);
        add_step(STEP_WRITE, ADDR_RESET, 32'd0, 32'd0);
        add_step(STEP_WAIT_RUN, '0, '0, '0);
        add_step(STEP_READ, ADDR_DIP, '0, 32'h96A5_3C5A);

        repeat (10) @(posedge clk_74a);
        temp_reset <= 1'b0;
        @(negedge clk_74a);
        step_errors = 0;
        check_run(core_run, 1'b0);
        check_inputs(core_inputs, expected_core());
        check_word("bridge_rd_data", bridge_rd_data, '0);
        report_step(0, "reset");

        foreach (steps[i]) begin
            step_errors = 0;
            case (steps[i].kind)
                STEP_WRITE: do_write(steps[i]);
                STEP_READ:  do_read(steps[i]);
                STEP_PAD:   do_pad();
                default:    wait_for_run();
            endcase
            report_step(i + 1, kind_name(steps[i].kind));
        end

        $display("steps: %0d passed, %0d failed", passed_steps, failed_steps);
        if (failed_steps == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
verilog/arcade_shell_pkg.sv
verilog/bridge_settings_regs.sv
verilog/player_input_merge.sv
verilog/core_control_stage.sv
verilog/arcade_host_shell.sv
sim/arcade_host_shell_tb.sv

// File: Makefile
# Verilator simulation of the arcade host shell

VERILATOR ?= verilator
TOP       ?= arcade_host_shell_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= Simulation passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
